//--- verilog/k051960_pkg.sv
// Sprite generator shared definitions
// Bus and counter widths, raster limits and CPU register map
`default_nettype none

package k051960_pkg;

	// Widths with a meaning of their own
	typedef logic [8:0]  hpos_t;
	typedef logic [8:0]  row_t;
	typedef logic [10:0] cpu_addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [17:0] rom_addr_t;

	// Horizontal count range, 384 pixels per line
	localparam hpos_t H_START = 9'h020;
	localparam hpos_t H_END   = 9'h19F;

	// Row range, 264 lines per frame
	localparam row_t V_START = 9'h0F8;
	localparam row_t V_END   = 9'h1FF;

	// Blanking starts at VBL_ON, ends at VBL_OFF
	localparam row_t VBL_ON  = 9'h1F0;
	localparam row_t VBL_OFF = 9'h110;

	// Register numbers on ab[2:0]
	localparam logic [2:0] REG0_ADDR = 3'd0;
	localparam logic [2:0] REG2_ADDR = 3'd2;
	localparam logic [2:0] REG3_ADDR = 3'd3;
	localparam logic [2:0] REG4_ADDR = 3'd4;

	// Register 0 control bits
	localparam int RB_ROM_READ = 0;
	localparam int RB_IRQ_EN   = 1;
	localparam int RB_FIRQ_EN  = 2;
	localparam int RB_NMI_EN   = 5;

endpackage

`default_nettype wire

//--- verilog/raster_counter.sv
// Raster timing
// Pixel and line counters, vertical blank window and frame sync
`timescale 1ns/1ps
`default_nettype none

module raster_counter (
	input  wire                 clk_6M,
	input  wire                 RES_SYNC,
	output k051960_pkg::hpos_t  hpos,
	output k051960_pkg::row_t   row,
	output logic                vblank,
	output logic                hvot,
	output logic                p1h,
	output logic                p2h
);

	logic line_end;

	assign line_end = (hpos == k051960_pkg::H_END);

	// Pixel counter, 0x020 to 0x19F
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			hpos <= k051960_pkg::H_START;
		end else if (line_end) begin
			hpos <= k051960_pkg::H_START;
		end else begin
			hpos <= hpos + 9'd1;
		end
	end

	// Row counter steps at the last pixel of each line
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			row <= k051960_pkg::V_START;
		end else if (line_end) begin
			if (row == k051960_pkg::V_END) begin
				row <= k051960_pkg::V_START;
			end else begin
				row <= row + 9'd1;
			end
		end
	end

	// Blank spans the frame wrap, 16 rows before it and 24 after
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			vblank <= 1'b0;
		end else if (row == k051960_pkg::VBL_ON) begin
			vblank <= 1'b1;
		end else if (row == k051960_pkg::VBL_OFF) begin
			vblank <= 1'b0;
		end
	end

	// Frame sync low for the whole last row
	assign hvot = (row != k051960_pkg::V_END);

	// Pixel clock phases
	assign p1h = hpos[0];
	assign p2h = hpos[1];

endmodule

`default_nettype wire

//--- verilog/cpu_regs.sv
// CPU register file
// Decodes the register window and holds control registers 0, 2, 3 and 4
`timescale 1ns/1ps
`default_nettype none

module cpu_regs (
	input  wire                     clk_6M,
	input  wire                     RES_SYNC,
	input  wire                     obcs,
	input  wire                     nrd,
	input  wire k051960_pkg::cpu_addr_t ab,
	input  wire k051960_pkg::byte_t db_in,
	output logic                    rom_read,
	output logic                    irq_en,
	output logic                    firq_en,
	output logic                    nmi_en,
	output k051960_pkg::byte_t      reg2,
	output k051960_pkg::byte_t      reg3,
	output logic [1:0]              reg4,
	output logic                    reg0_rd
);

	logic       reg_win;
	logic       reg_wr;
	logic [2:0] reg_sel;

	// Registers live where ab[10:3] is all zero
	assign reg_win = !obcs && (ab[10:3] == 8'h00);
	assign reg_wr  = reg_win && nrd;
	assign reg_sel = ab[2:0];

	// Status read of register 0
	assign reg0_rd = reg_win && !nrd && (reg_sel == k051960_pkg::REG0_ADDR);

	// Write level, repeats every cycle while held
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			rom_read <= 1'b0;
			irq_en   <= 1'b0;
			firq_en  <= 1'b0;
			nmi_en   <= 1'b0;
			reg2     <= '0;
			reg3     <= '0;
			reg4     <= 2'b00;
		end else if (reg_wr) begin
			case (reg_sel)
				k051960_pkg::REG0_ADDR: begin
					rom_read <= db_in[k051960_pkg::RB_ROM_READ];
					irq_en   <= db_in[k051960_pkg::RB_IRQ_EN];
					firq_en  <= db_in[k051960_pkg::RB_FIRQ_EN];
					nmi_en   <= db_in[k051960_pkg::RB_NMI_EN];
				end
				// ROM bank high bits
				k051960_pkg::REG2_ADDR: begin
					reg2 <= db_in;
				end
				k051960_pkg::REG3_ADDR: begin
					reg3 <= db_in;
				end
				// Only two bits exist in register 4
				k051960_pkg::REG4_ADDR: begin
					reg4 <= db_in[1:0];
				end
				// Registers 1, 5, 6 and 7 are not implemented
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/frame_events.sv
// Interrupt and reset sequencing
// IRQ at blank start, FIRQ every 2 lines, NMI every 32 lines, delayed reset
`timescale 1ns/1ps
`default_nettype none

module frame_events #(
	parameter int RST_FRAMES = 8
) (
	input  wire                    clk_6M,
	input  wire                    RES_SYNC,
	input  wire k051960_pkg::row_t row,
	input  wire                    vblank,
	input  wire                    irq_en,
	input  wire                    firq_en,
	input  wire                    nmi_en,
	output logic                   irq,
	output logic                   firq,
	output logic                   nmi,
	output logic                   rst
);

	localparam int CNT_W = $clog2(RST_FRAMES + 1);

	logic             vblank_d;
	logic             row0_d;
	logic             row2_d;
	logic             vblank_rise;
	logic             row0_rise;
	logic             row2_rise;
	logic [1:0]       nmi_div;
	logic             nmi_tick;
	logic [CNT_W-1:0] frame_cnt;

	assign vblank_rise = vblank && !vblank_d;
	assign row0_rise   = row[0] && !row0_d;
	assign row2_rise   = row[2] && !row2_d;

	// Bit 1 of the divider rises every fourth step, so every 32 lines
	assign nmi_tick = row2_rise && (nmi_div == 2'b01);

	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			vblank_d <= 1'b0;
			row0_d   <= 1'b0;
			row2_d   <= 1'b0;
			nmi_div  <= 2'b00;
		end else begin
			vblank_d <= vblank;
			row0_d   <= row[0];
			row2_d   <= row[2];
			if (row2_rise) begin
				nmi_div <= nmi_div + 2'd1;
			end
		end
	end

	// Active low flags, held until the enable goes to zero
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			irq  <= 1'b1;
			firq <= 1'b1;
			nmi  <= 1'b1;
		end else begin
			if (!irq_en) begin
				irq <= 1'b1;
			end else if (vblank_rise) begin
				irq <= 1'b0;
			end
			if (!firq_en) begin
				firq <= 1'b1;
			end else if (row0_rise) begin
				firq <= 1'b0;
			end
			if (!nmi_en) begin
				nmi <= 1'b1;
			end else if (nmi_tick) begin
				nmi <= 1'b0;
			end
		end
	end

	// Delayed system reset counts blanking starts and then saturates
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			frame_cnt <= '0;
		end else if (vblank_rise && !rst) begin
			frame_cnt <= frame_cnt + 1'b1;
		end
	end

	assign rst = (frame_cnt == CNT_W'(RST_FRAMES));

endmodule

`default_nettype wire

//--- verilog/rom_readback.sv
// Graphics ROM read-back and CPU bus output
// Builds ROM address and colour byte, drives status read and bus direction
`timescale 1ns/1ps
`default_nettype none

module rom_readback (
	input  wire                         clk_6M,
	input  wire                         RES_SYNC,
	input  wire                         obcs,
	input  wire                         nrd,
	input  wire k051960_pkg::cpu_addr_t ab,
	input  wire                         rom_read,
	input  wire k051960_pkg::byte_t     reg2,
	input  wire k051960_pkg::byte_t     reg3,
	input  wire [1:0]                   reg4,
	input  wire                         reg0_rd,
	input  wire                         vblank,
	output k051960_pkg::rom_addr_t      ca,
	output k051960_pkg::byte_t          oc,
	output k051960_pkg::byte_t          db_out,
	output logic                        db_dir
);

	logic               rom_acc;
	k051960_pkg::byte_t ab_lat;

	// ROM window is the upper half of the chip space
	assign rom_acc = !obcs && ab[10];

	// Word address captured at the end of each ROM access cycle
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			ab_lat <= '0;
		end else if (rom_acc) begin
			ab_lat <= ab[9:2];
		end
	end

	// Bank from registers 3 and 2, low byte from the CPU
	assign ca = rom_read ? {reg3[1:0], reg2, ab_lat} : '0;
	assign oc = rom_read ? {reg4, reg3[7:2]} : '0;

	// Status bit 0 reads high outside blanking
	assign db_out = reg0_rd ? {7'b000_0000, !vblank} : '0;

	assign db_dir = reg0_rd || (rom_acc && !nrd && rom_read);

endmodule

`default_nettype wire

//--- verilog/k051960_top.sv
// Sprite generator, CPU and frame timing part
// Connects register file, raster timing, interrupt logic and ROM read-back
`timescale 1ns/1ps
`default_nettype none

module k051960_top #(
	parameter int RST_FRAMES = 8
) (
	input  wire                         clk_6M,
	input  wire                         RES_SYNC,
	input  wire                         obcs,
	input  wire                         nrd,
	input  wire k051960_pkg::cpu_addr_t ab,
	input  wire k051960_pkg::byte_t     db_in,
	output wire k051960_pkg::byte_t     db_out,
	output wire                         db_dir,
	output wire                         p1h,
	output wire                         p2h,
	output wire                         hvot,
	output wire                         irq,
	output wire                         firq,
	output wire                         nmi,
	output wire                         rst,
	output wire k051960_pkg::rom_addr_t ca,
	output wire k051960_pkg::byte_t     oc
);

	wire k051960_pkg::hpos_t hpos;
	wire k051960_pkg::row_t  row;
	wire                     vblank;
	wire                     rom_read;
	wire                     irq_en;
	wire                     firq_en;
	wire                     nmi_en;
	wire k051960_pkg::byte_t reg2;
	wire k051960_pkg::byte_t reg3;
	wire [1:0]               reg4;
	wire                     reg0_rd;

	cpu_regs u_cpu_regs (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.obcs     (obcs),
		.nrd      (nrd),
		.ab       (ab),
		.db_in    (db_in),
		.rom_read (rom_read),
		.irq_en   (irq_en),
		.firq_en  (firq_en),
		.nmi_en   (nmi_en),
		.reg2     (reg2),
		.reg3     (reg3),
		.reg4     (reg4),
		.reg0_rd  (reg0_rd)
	);

	raster_counter u_raster_counter (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.hpos     (hpos),
		.row      (row),
		.vblank   (vblank),
		.hvot     (hvot),
		.p1h      (p1h),
		.p2h      (p2h)
	);

	frame_events #(
		.RST_FRAMES (RST_FRAMES)
	) u_frame_events (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.row      (row),
		.vblank   (vblank),
		.irq_en   (irq_en),
		.firq_en  (firq_en),
		.nmi_en   (nmi_en),
		.irq      (irq),
		.firq     (firq),
		.nmi      (nmi),
		.rst      (rst)
	);

	rom_readback u_rom_readback (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.obcs     (obcs),
		.nrd      (nrd),
		.ab       (ab),
		.rom_read (rom_read),
		.reg2     (reg2),
		.reg3     (reg3),
		.reg4     (reg4),
		.reg0_rd  (reg0_rd),
		.vblank   (vblank),
		.ca       (ca),
		.oc       (oc),
		.db_out   (db_out),
		.db_dir   (db_dir)
	);

endmodule

`default_nettype wire

//--- dv/k051960_asserts.sv
// Concurrent checks bound into the sprite generator top level
// Frame sync window, ROM address gating and FIRQ enable gating
`timescale 1ns/1ps
`default_nettype none

module k051960_asserts (
	input wire                         clk_6M,
	input wire                         RES_SYNC,
	input wire                         obcs,
	input wire                         nrd,
	input wire k051960_pkg::cpu_addr_t ab,
	input wire k051960_pkg::byte_t     db_in,
	input wire k051960_pkg::hpos_t     hpos,
	input wire k051960_pkg::row_t      row,
	input wire                         hvot,
	input wire k051960_pkg::rom_addr_t ca,
	input wire                         firq
);

	logic reg0_wr;
	logic rom_off;
	logic firq_off;

	assign reg0_wr = !obcs && nrd && (ab == {8'h00, k051960_pkg::REG0_ADDR});

	// Control bits as last written over the CPU bus
	always_ff @(posedge clk_6M or negedge RES_SYNC) begin
		if (!RES_SYNC) begin
			rom_off  <= 1'b1;
			firq_off <= 1'b1;
		end else if (reg0_wr) begin
			rom_off  <= !db_in[k051960_pkg::RB_ROM_READ];
			firq_off <= !db_in[k051960_pkg::RB_FIRQ_EN];
		end
	end

	// Frame sync falls only as the row steps into V_END
	hvot_falls_into_last_row: assert property (
		@(posedge clk_6M) disable iff (!RES_SYNC)
		$fell(hvot) |-> ($past(hpos) == k051960_pkg::H_END)
			&& ($past(row) == k051960_pkg::V_END - 9'd1)
	) else $error("hvot fell outside the step into row V_END");

	hvot_rises_at_wrap: assert property (
		@(posedge clk_6M) disable iff (!RES_SYNC)
		$rose(hvot) |-> ($past(hpos) == k051960_pkg::H_END)
			&& (row == k051960_pkg::V_START)
	) else $error("hvot rose outside the frame wrap");

	ca_zero_when_off: assert property (
		@(posedge clk_6M) disable iff (!RES_SYNC)
		rom_off |-> (ca == '0)
	) else $error("ca not zero while ROM read-back is off");

	// FIRQ clears one cycle after its enable drops
	firq_idle_when_off: assert property (
		@(posedge clk_6M) disable iff (!RES_SYNC)
		(firq_off && $past(firq_off)) |-> firq
	) else $error("firq low while firq_en is clear");

endmodule

bind k051960_top k051960_asserts u_asserts (
	.clk_6M   (clk_6M),
	.RES_SYNC (RES_SYNC),
	.obcs     (obcs),
	.nrd      (nrd),
	.ab       (ab),
	.db_in    (db_in),
	.hpos     (hpos),
	.row      (row),
	.hvot     (hvot),
	.ca       (ca),
	.firq     (firq)
);

`default_nettype wire

//--- dv/tb_k051960.sv
// Directed testbench for the sprite generator CPU and frame timing part
// Covers reset, raster timing, status read, interrupts and ROM read-back
`timescale 1ns/1ps
`default_nettype none

module tb_k051960;

	localparam int RST_FRAMES   = 8;
	localparam int LINE_CYCLES  = 384;
	localparam int FRAME_CYCLES = 101376;
	localparam int BLANK_CYCLES = 40 * LINE_CYCLES;
	// Delayed reset alone needs about eight frames, the frame tests about three more
	localparam int TIMEOUT_CYCLES = 1200000;
	localparam k051960_pkg::byte_t EN_BOTH = 8'h24;

	logic                   clk_6M;
	logic                   RES_SYNC;
	logic                   obcs;
	logic                   nrd;
	k051960_pkg::cpu_addr_t ab;
	k051960_pkg::byte_t     db_in;
	wire k051960_pkg::byte_t     db_out;
	wire                         db_dir;
	wire                         p1h;
	wire                         p2h;
	wire                         hvot;
	wire                         irq;
	wire                         firq;
	wire                         nmi;
	wire                         rst;
	wire k051960_pkg::rom_addr_t ca;
	wire k051960_pkg::byte_t     oc;

	int          errors;
	int unsigned cycles = 0;
	integer      seed;

	k051960_top #(
		.RST_FRAMES (RST_FRAMES)
	) u_dut (
		.clk_6M   (clk_6M),
		.RES_SYNC (RES_SYNC),
		.obcs     (obcs),
		.nrd      (nrd),
		.ab       (ab),
		.db_in    (db_in),
		.db_out   (db_out),
		.db_dir   (db_dir),
		.p1h      (p1h),
		.p2h      (p2h),
		.hvot     (hvot),
		.irq      (irq),
		.firq     (firq),
		.nmi      (nmi),
		.rst      (rst),
		.ca       (ca),
		.oc       (oc)
	);

	initial begin
		clk_6M = 1'b0;
		forever #5 clk_6M = ~clk_6M;
	end

	always @(posedge clk_6M) begin
		cycles <= cycles + 1;
	end

	initial begin
		wait (cycles >= TIMEOUT_CYCLES);
		$display("Timeout after %0d cycles, the tests did not finish", cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic write_reg(input logic [2:0] num, input k051960_pkg::byte_t data);
		@(posedge clk_6M);
		obcs  <= 1'b0;
		nrd   <= 1'b1;
		ab    <= {8'h00, num};
		db_in <= data;
		@(posedge clk_6M);
		obcs <= 1'b1;
	endtask

	// Register 0 read held as a level
	task automatic start_status_read();
		@(posedge clk_6M);
		obcs <= 1'b0;
		nrd  <= 1'b0;
		ab   <= '0;
		@(negedge clk_6M);
	endtask

	task automatic test_reset_state();
		int   starts;
		int   irq_lows;
		logic prev_st;
		check_value("irq", irq, 1);
		check_value("firq", firq, 1);
		check_value("nmi", nmi, 1);
		check_value("rst", rst, 0);
		check_value("ca", ca, 0);
		check_value("oc", oc, 0);
		start_status_read();
		prev_st  = db_out[0];
		starts   = 0;
		irq_lows = 0;
		// irq_en is still clear, so irq must stay high across every blank start
		while (!rst && starts <= RST_FRAMES) begin
			@(negedge clk_6M);
			if (prev_st && !db_out[0]) starts++;
			if (!irq) irq_lows++;
			prev_st = db_out[0];
		end
		check_value("blank starts before rst", starts, RST_FRAMES);
		check_value("irq lows with irq_en clear", irq_lows, 0);
		check_value("rst", rst, 1);
	endtask

	task automatic test_frame_timing();
		int unsigned t_fall;
		int unsigned t_rise;
		int unsigned t_next;
		int          toggles;
		int          p2h_bad;
		logic        prev_p1h;
		logic        prev_p2h;
		prev_p1h = p1h;
		prev_p2h = p2h;
		toggles  = 0;
		p2h_bad  = 0;
		repeat (16) begin
			@(negedge clk_6M);
			if (p1h != prev_p1h) toggles++;
			// p2h steps exactly when p1h falls
			if ((p2h != prev_p2h) != (prev_p1h && !p1h)) p2h_bad++;
			prev_p1h = p1h;
			prev_p2h = p2h;
		end
		check_value("p1h toggles", toggles, 16);
		check_value("p2h phase errors", p2h_bad, 0);
		while (!hvot) @(negedge clk_6M);
		while (hvot) @(negedge clk_6M);
		t_fall = cycles;
		while (!hvot) @(negedge clk_6M);
		t_rise = cycles;
		while (hvot) @(negedge clk_6M);
		t_next = cycles;
		check_value("hvot low cycles", t_rise - t_fall, LINE_CYCLES);
		check_value("hvot frame cycles", t_next - t_fall, FRAME_CYCLES);
	endtask

	task automatic test_vblank_status();
		int unsigned t_fall;
		int          dir_low;
		start_status_read();
		check_value("db_dir", db_dir, 1);
		dir_low = 0;
		while (!db_out[0]) @(negedge clk_6M);
		while (db_out[0]) @(negedge clk_6M);
		t_fall = cycles;
		while (!db_out[0]) begin
			@(negedge clk_6M);
			if (!db_dir) dir_low++;
		end
		check_value("blank status cycles", cycles - t_fall, BLANK_CYCLES);
		check_value("db_dir lows during read", dir_low, 0);
		check_value("db_out[7:1]", db_out[7:1], 0);
		@(posedge clk_6M);
		obcs <= 1'b1;
		nrd  <= 1'b1;
		@(negedge clk_6M);
		check_value("db_dir", db_dir, 0);
		check_value("db_out", db_out, 0);
	endtask

	task automatic test_irq();
		int unsigned t_blank;
		write_reg(k051960_pkg::REG0_ADDR, 8'h02);
		start_status_read();
		while (db_out[0]) @(negedge clk_6M);
		t_blank = cycles;
		while (irq && (cycles - t_blank) < 3) @(negedge clk_6M);
		check_value("irq", irq, 0);
		check_value("irq delay within 2", (cycles - t_blank) <= 2, 1);
		repeat (100) @(negedge clk_6M);
		check_value("irq held", irq, 0);
		write_reg(k051960_pkg::REG0_ADDR, 8'h00);
		repeat (2) @(negedge clk_6M);
		check_value("irq after clear", irq, 1);
	endtask

	task automatic test_firq_nmi();
		int unsigned        last_firq;
		int unsigned        last_nmi;
		int                 n_firq;
		int                 n_nmi;
		k051960_pkg::byte_t clr;
		n_firq    = 0;
		n_nmi     = 0;
		last_firq = 0;
		last_nmi  = 0;
		write_reg(k051960_pkg::REG0_ADDR, EN_BOTH);
		while (n_nmi < 2) begin
			@(negedge clk_6M);
			clr = EN_BOTH;
			if (!firq) begin
				if (n_firq > 0) check_value("firq spacing", cycles - last_firq, 2 * LINE_CYCLES);
				last_firq = cycles;
				n_firq++;
				clr[2] = 1'b0;
			end
			if (!nmi) begin
				if (n_nmi > 0) check_value("nmi spacing", cycles - last_nmi, 32 * LINE_CYCLES);
				last_nmi = cycles;
				n_nmi++;
				clr[5] = 1'b0;
			end
			// Drop the enable of whatever fired, then arm both again
			if (clr != EN_BOTH) begin
				write_reg(k051960_pkg::REG0_ADDR, clr);
				write_reg(k051960_pkg::REG0_ADDR, EN_BOTH);
			end
		end
		check_value("firq events", n_firq >= 16, 1);
		write_reg(k051960_pkg::REG0_ADDR, 8'h00);
	endtask

	task automatic test_rom_readback();
		k051960_pkg::byte_t     r2;
		k051960_pkg::byte_t     r3;
		k051960_pkg::byte_t     r4;
		k051960_pkg::cpu_addr_t addr;
		int                     i;
		for (i = 0; i < 4; i++) begin
			r2   = 8'($random(seed));
			r3   = 8'($random(seed));
			r4   = 8'($random(seed));
			addr = 11'($random(seed)) | 11'h400;
			write_reg(k051960_pkg::REG2_ADDR, r2);
			write_reg(k051960_pkg::REG3_ADDR, r3);
			write_reg(k051960_pkg::REG4_ADDR, r4);
			write_reg(k051960_pkg::REG0_ADDR, 8'h01);
			@(posedge clk_6M);
			obcs <= 1'b0;
			nrd  <= 1'b0;
			ab   <= addr;
			@(negedge clk_6M);
			check_value("db_dir on ROM read", db_dir, 1);
			@(posedge clk_6M);
			obcs <= 1'b1;
			nrd  <= 1'b1;
			ab   <= '0;
			@(negedge clk_6M);
			check_value("ca", ca, {r3[1:0], r2, addr[9:2]});
			check_value("oc", oc, {r4[1:0], r3[7:2]});
		end
		write_reg(k051960_pkg::REG0_ADDR, 8'h00);
		@(negedge clk_6M);
		check_value("ca off", ca, 0);
		check_value("oc off", oc, 0);
	endtask

	initial begin
		RES_SYNC = 1'b0;
		obcs     = 1'b1;
		nrd      = 1'b1;
		ab       = '0;
		db_in    = '0;
		errors   = 0;
		seed     = 7364;
		repeat (8) @(posedge clk_6M);
		RES_SYNC <= 1'b1;
		@(negedge clk_6M);
		test_reset_state();
		test_frame_timing();
		test_vblank_status();
		test_irq();
		test_firq_nmi();
		test_rom_readback();
		$display("Run complete after %0d cycles with %0d errors", cycles, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
verilog/k051960_pkg.sv
verilog/raster_counter.sv
verilog/cpu_regs.sv
verilog/frame_events.sv
verilog/rom_readback.sv
verilog/k051960_top.sv
dv/k051960_asserts.sv
dv/tb_k051960.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_k051960 \
	-f src.f -o sim_k051960 \
	&& ./obj_dir/sim_k051960 > sim.log 2>&1 \
	|| echo "Build or run of the simulation failed"
cat sim.log 2>/dev/null
grep -q "^SIMULATION PASSED$" sim.log && echo "Result: pass" || { echo "Result: fail"; exit 1; }
